// File: Makefile
# Verilator build and run for the reverb testbench

TOP = reverb_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

# the run passes only if the pass line shows up in the output
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// File: dv/reverb_tb.sv
`default_nettype none

module reverb_tb;
  import reverb_pkg::*;

  localparam int SAMPLE_PERIOD = 24;                       // cycles between samples
  localparam int TOTAL_SAMPLES = 8 + 21 + 40 + 37;         // tests 1, 3, 4 and 5
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * SAMPLE_PERIOD + 400;

  logic          audio_clk;
  logic          reset;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  audio_sample_t sample;
  conv_result_t  result;

  // reference model state
  logic signed [SAMPLE_W-1:0] model_hist [IR_LEN];  // model_hist[0] newest
  logic signed [SAMPLE_W-1:0] model_ir [IR_LEN];
  logic                       model_ready;
  logic                       model_recording;
  int                         model_skip;
  int                         model_cnt;
  logic signed [ACC_W-1:0]    exp_q [$];
  logic signed [ACC_W-1:0]    expected_data;

  int errors;
  int test_err_base;
  int failed_tests;
  int n_results;
  int n_sent;

  reverb_top uut (
    .audio_clk (audio_clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .sample    (sample),
    .result    (result)
  );

  initial begin
    audio_clk = 1'b0;
    forever #5 audio_clk = ~audio_clk;
  end

  // h[k] * x[n-k] summed over all taps
  function automatic logic signed [ACC_W-1:0] dot_product();
    logic signed [ACC_W-1:0]      sum;
    logic signed [2*SAMPLE_W-1:0] prod;
    sum = '0;
    for (int k = 0; k < IR_LEN; k++) begin
      prod = model_ir[k] * model_hist[k];
      sum  = sum + prod;
    end
    return sum;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERR time=%0t signal=%s got=%h expected=%h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    int n;
    n = errors - test_err_base;
    if (n == 0) begin
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s (%0d errors)", name, n);
      failed_tests++;
    end
    test_err_base = errors;
  endtask

  // called on a falling edge, returns on a falling edge after one idle cycle
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(negedge audio_clk);
    apb_req.penable = 1'b1;
    @(negedge audio_clk);
    apb_req = '0;
    @(negedge audio_clk);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic slverr);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
    @(negedge audio_clk);
    apb_req.penable = 1'b1;
    data   = apb_rsp.prdata;  // registered at the setup edge
    slverr = apb_rsp.pslverr;
    check_value("pready", 64'(apb_rsp.pready), 64'd1);
    @(negedge audio_clk);
    apb_req = '0;
    @(negedge audio_clk);
  endtask

  task automatic check_status(input logic [31:0] expected);
    logic [31:0] data;
    logic        slverr;
    apb_read(REG_STATUS, data, slverr);
    check_value("STATUS", data, expected);
    check_value("pslverr", 64'(slverr), 64'd0);
  endtask

  task automatic start_recording(input logic [DELAY_W-1:0] delay);
    apb_write(REG_DELAY, 32'(delay));
    apb_write(REG_CTRL, 32'h1);
    model_skip      = delay;
    model_cnt       = 0;
    model_recording = 1'b1;
    model_ready     = 1'b0;
  endtask

  task automatic send_sample();
    logic [31:0]                rnd;
    logic signed [SAMPLE_W-1:0] data;
    rnd  = $urandom();
    data = rnd[SAMPLE_W-1:0];
    for (int i = IR_LEN - 1; i > 0; i--) begin
      model_hist[i] = model_hist[i-1];
    end
    model_hist[0] = data;
    if (model_ready) begin
      exp_q.push_back(dot_product());  // engine only runs with ir_ready already up
    end
    if (model_recording) begin
      if (model_skip > 0) begin
        model_skip--;
      end else begin
        model_ir[model_cnt] = data;
        model_cnt++;
        if (model_cnt == IR_LEN) begin
          model_recording = 1'b0;
          model_ready     = 1'b1;
        end
      end
    end
    sample = '{valid: 1'b1, data: data};
    @(negedge audio_clk);
    sample.valid = 1'b0;
    repeat (SAMPLE_PERIOD - 1) @(negedge audio_clk);
    n_sent++;
  endtask

  // result is registered, stable at the falling edge
  always @(negedge audio_clk) begin
    if (!reset && result.valid) begin
      n_results++;
      if (exp_q.size() == 0) begin
        $display("unexpected result at time %0t with no sample waiting for one", $time);
        errors++;
      end else begin
        expected_data = exp_q.pop_front();
        check_value("result.data", result.data, expected_data);
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic        slverr;
    int          n_before;
    logic [7:0]  offsets [3];

    void'($urandom(77));
    reset           = 1'b1;
    apb_req         = '0;
    sample          = '0;
    model_ready     = 1'b0;
    model_recording = 1'b0;
    model_skip      = 0;
    model_cnt       = 0;
    errors          = 0;
    test_err_base   = 0;
    failed_tests    = 0;
    n_results       = 0;
    n_sent          = 0;
    offsets         = '{REG_CTRL, REG_DELAY, REG_STATUS};
    for (int i = 0; i < IR_LEN; i++) begin
      model_hist[i] = '0;
      model_ir[i]   = '0;
    end
    repeat (2) @(negedge audio_clk);
    reset = 1'b0;

    // 1: idle after reset
    check_status(32'h0);
    repeat (8) send_sample();
    check_value("result count", 64'(n_results), 64'd0);
    report_test("reset state and no results without a response");

    // 2: register access
    apb_write(REG_DELAY, 32'hA5);
    apb_read(REG_DELAY, rdata, slverr);
    check_value("DELAY", rdata, 32'hA5);
    apb_read(8'h0C, rdata, slverr);
    check_value("pslverr", 64'(slverr), 64'd1);
    foreach (offsets[i]) begin
      apb_read(offsets[i], rdata, slverr);
      check_value("pslverr", 64'(slverr), 64'd0);
    end
    report_test("register readback and address decode");

    // 3: record with delay 5
    start_recording(8'd5);
    check_status(32'h2);
    repeat (10) send_sample();
    check_status(32'h2);  // still inside delay and capture
    repeat (11) send_sample();
    check_status(32'h1);
    report_test("recording with delay 5");

    // 4: convolution against the model
    n_before = n_results;
    repeat (40) send_sample();
    check_value("result count", 64'(n_results - n_before), 64'd40);
    check_value("pending results", 64'(exp_q.size()), 64'd0);
    report_test("forty convolution results");

    // 5: re-record while streaming
    send_sample();
    n_before = n_results;
    start_recording(8'd0);
    check_status(32'h2);
    repeat (IR_LEN) send_sample();
    check_value("result count during capture", 64'(n_results - n_before), 64'd0);
    check_status(32'h1);
    repeat (20) send_sample();
    check_value("result count", 64'(n_results - n_before), 64'd20);
    report_test("re-recording with delay 0");

    if (exp_q.size() != 0) begin
      $display("%0d expected results never appeared", exp_q.size());
      errors++;
    end
    $display("summary: 5 tests, %0d failed, %0d errors, %0d samples, %0d results",
             failed_tests, errors, n_sent, n_results);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/reverb_pkg.sv
logic/apb_ctrl_regs.sv
logic/impulse_recorder.sv
logic/convolution_engine.sv
logic/ir_memory_arbiter.sv
logic/reverb_top.sv
dv/reverb_tb.sv

// File: logic/apb_ctrl_regs.sv
`default_nettype none

module apb_ctrl_regs (
  input  logic                           audio_clk,
  input  logic                           reset,
  input  reverb_pkg::apb_req_t           apb_req,
  output reverb_pkg::apb_rsp_t           apb_rsp,
  input  logic                           ir_ready,
  input  logic                           recording,
  output logic                           record_start,
  output logic [reverb_pkg::DELAY_W-1:0] delay_len
);
  import reverb_pkg::*;

  logic        setup_phase;
  logic        access_phase;
  logic        addr_ok;
  logic [31:0] rd_mux;
  logic [31:0] prdata_q;
  logic        pslverr_q;

  assign setup_phase  = apb_req.psel && !apb_req.penable;
  assign access_phase = apb_req.psel && apb_req.penable;

  // read data and decode, paddr is stable from setup through access
  always_comb begin
    addr_ok = 1'b1;
    case (apb_req.paddr)
      REG_CTRL:   rd_mux = '0;  // start bit is self-clearing
      REG_DELAY:  rd_mux = {{(32 - DELAY_W){1'b0}}, delay_len};
      REG_STATUS: rd_mux = {30'b0, recording, ir_ready};
      default: begin
        rd_mux  = '0;
        addr_ok = 1'b0;
      end
    endcase
  end

  // captured in setup so it is on the bus during access
  always_ff @(posedge audio_clk) begin
    if (setup_phase) begin
      prdata_q <= rd_mux;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      pslverr_q    <= 1'b0;
      record_start <= 1'b0;
      delay_len    <= '0;
    end else begin
      pslverr_q    <= setup_phase && !addr_ok;  // high for the access cycle only
      record_start <= access_phase && apb_req.pwrite &&
                      (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
      if (access_phase && apb_req.pwrite && (apb_req.paddr == REG_DELAY)) begin
        delay_len <= apb_req.pwdata[DELAY_W-1:0];
      end
    end
  end

  assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};

  // access cycle must follow a setup cycle of the same transfer
  a_apb_phases: assert property (@(posedge audio_clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel && $past(setup_phase));

endmodule

`default_nettype wire

// File: logic/convolution_engine.sv
`default_nettype none

module convolution_engine (
  input  logic                            audio_clk,
  input  logic                            reset,
  input  reverb_pkg::audio_sample_t       sample,
  input  logic                            ir_ready,
  output reverb_pkg::ir_mem_req_t         mem_req,
  input  logic                            mem_grant,
  input  logic [reverb_pkg::SAMPLE_W-1:0] mem_rdata,
  output reverb_pkg::conv_result_t        result
);
  import reverb_pkg::*;

  conv_state_t                state;
  logic [IR_ADDR_W-1:0]       tap;               // tap being requested
  logic signed [SAMPLE_W-1:0] hist [IR_LEN];     // hist[0] is the newest sample

  logic                       rd_valid;          // rdata for rd_tap arrives now
  logic [IR_ADDR_W-1:0]       rd_tap;
  logic                       mul_valid;
  logic                       mul_first;
  logic                       mul_last;
  logic signed [2*SAMPLE_W-1:0] product;
  logic signed [ACC_W-1:0]    product_ext;
  logic signed [ACC_W-1:0]    acc;
  logic                       res_valid;

  // history shifts on every sample regardless of state
  always_ff @(posedge audio_clk) begin
    if (sample.valid) begin
      hist[0] <= sample.data;
      for (int i = 1; i < IR_LEN; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      state <= CONV_IDLE;
      tap   <= '0;
    end else if (!ir_ready) begin
      state <= CONV_IDLE;  // response is being replaced, abandon
      tap   <= '0;
    end else begin
      case (state)
        CONV_IDLE: begin
          if (sample.valid) begin
            state <= CONV_RUN;
            tap   <= '0;
          end
        end
        CONV_RUN: begin
          if (mem_grant) begin
            tap <= tap + 1'b1;
            if (tap == IR_ADDR_W'(IR_LEN - 1)) begin
              state <= CONV_DRAIN;
            end
          end
        end
        CONV_DRAIN: begin
          if (mul_valid && mul_last) begin
            state <= CONV_IDLE;
          end
        end
        default: state <= CONV_IDLE;
      endcase
    end
  end

  // read only, held while the recorder has the memory
  always_comb begin
    mem_req      = '0;
    mem_req.req  = (state == CONV_RUN);
    mem_req.addr = tap;
  end

  // pipeline valids, cleared as soon as ir_ready drops
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      rd_valid  <= 1'b0;
      mul_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      rd_valid  <= mem_grant && ir_ready;
      mul_valid <= rd_valid && ir_ready;
      res_valid <= mul_valid && mul_last && ir_ready;
    end
  end

  assign product_ext = product;  // sign extends to 40 bits

  always_ff @(posedge audio_clk) begin
    rd_tap    <= tap;
    mul_first <= (rd_tap == '0);
    mul_last  <= (rd_tap == IR_ADDR_W'(IR_LEN - 1));
    product   <= $signed(mem_rdata) * hist[rd_tap];  // h[k] * x[n-k]
    if (mul_valid) begin
      acc <= mul_first ? product_ext : acc + product_ext;
    end
  end

  assign result = '{valid: res_valid, data: acc};

  // history must not move under a running dot product
  property p_sample_spacing;
    @(posedge audio_clk) disable iff (reset)
      sample.valid |=> !sample.valid [*(IR_LEN + 5)];
  endproperty
  a_sample_spacing: assert property (p_sample_spacing);

  // every grant the engine gets is a read it asked for
  a_read_only: assert property (@(posedge audio_clk) disable iff (reset)
    mem_grant |-> mem_req.req && !mem_req.we);

endmodule

`default_nettype wire

// File: logic/impulse_recorder.sv
`default_nettype none

module impulse_recorder (
  input  logic                           audio_clk,
  input  logic                           reset,
  input  reverb_pkg::audio_sample_t      sample,
  input  logic                           record_start,
  input  logic [reverb_pkg::DELAY_W-1:0] delay_len,
  output reverb_pkg::ir_mem_req_t        mem_req,
  input  logic                           mem_grant,
  output logic                           ir_ready,
  output logic                           recording
);
  import reverb_pkg::*;

  rec_state_t           state;
  logic [DELAY_W-1:0]   delay_cnt;  // samples still to skip
  logic [IR_ADDR_W-1:0] tap_addr;   // next IR slot to fill

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      state     <= REC_IDLE;
      delay_cnt <= '0;
      tap_addr  <= '0;
      mem_req   <= '0;
      ir_ready  <= 1'b0;
      recording <= 1'b0;
    end else if (record_start) begin
      // also restarts a recording in progress
      state       <= (delay_len == '0) ? REC_CAPTURE : REC_DELAY;
      delay_cnt   <= delay_len;
      tap_addr    <= '0;
      mem_req.req <= 1'b0;
      ir_ready    <= 1'b0;
      recording   <= 1'b1;
    end else begin
      case (state)
        REC_DELAY: begin
          if (sample.valid) begin
            delay_cnt <= delay_cnt - 1'b1;
            if (delay_cnt == DELAY_W'(1)) begin
              state <= REC_CAPTURE;
            end
          end
        end
        REC_CAPTURE: begin
          if (mem_req.req) begin
            if (mem_grant) begin
              mem_req.req <= 1'b0;
              tap_addr    <= tap_addr + 1'b1;
              if (tap_addr == IR_ADDR_W'(IR_LEN - 1)) begin  // last tap written
                state     <= REC_IDLE;
                recording <= 1'b0;
                ir_ready  <= 1'b1;
              end
            end
          end else if (sample.valid) begin
            mem_req <= '{req: 1'b1, we: 1'b1, addr: tap_addr, wdata: sample.data};
          end
        end
        default: ;
      endcase
    end
  end

  // the pending write must drain before the next sample shows up
  a_no_overrun: assert property (@(posedge audio_clk) disable iff (reset)
    sample.valid && (state == REC_CAPTURE) |-> !mem_req.req);

endmodule

`default_nettype wire

// File: logic/ir_memory_arbiter.sv
`default_nettype none

module ir_memory_arbiter (
  input  logic                            audio_clk,
  input  logic                            reset,
  input  reverb_pkg::ir_mem_req_t         rec_req,
  input  reverb_pkg::ir_mem_req_t         conv_req,
  output logic                            rec_grant,
  output logic                            conv_grant,
  output logic [reverb_pkg::SAMPLE_W-1:0] rdata
);
  import reverb_pkg::*;

  logic signed [SAMPLE_W-1:0] mem [IR_LEN];
  ir_mem_req_t                sel;  // winning request this cycle

  // recorder always wins
  assign rec_grant  = rec_req.req;
  assign conv_grant = conv_req.req && !rec_req.req;
  assign sel        = rec_req.req ? rec_req : conv_req;

  always_ff @(posedge audio_clk) begin
    if (sel.req && sel.we) begin
      mem[sel.addr] <= sel.wdata;
    end
  end

  // registered read, data valid the cycle after the grant
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (sel.req && !sel.we) begin
      rdata <= mem[sel.addr];
    end
  end

  a_one_grant: assert property (@(posedge audio_clk) disable iff (reset)
    !(rec_grant && conv_grant));

endmodule

`default_nettype wire

// File: logic/reverb_pkg.sv
`default_nettype none

package reverb_pkg;

  localparam int IR_LEN    = 16;   // taps in the impulse response
  localparam int IR_ADDR_W = 4;
  localparam int SAMPLE_W  = 16;
  localparam int ACC_W     = 40;   // 32-bit products plus headroom for 16 sums
  localparam int DELAY_W   = 8;

  // APB register map, byte offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_DELAY  = 8'h04;
  localparam logic [7:0] REG_STATUS = 8'h08;

  typedef struct packed {
    logic                       valid;
    logic signed [SAMPLE_W-1:0] data;
  } audio_sample_t;

  typedef struct packed {
    logic                    valid;
    logic signed [ACC_W-1:0] data;
  } conv_result_t;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [IR_ADDR_W-1:0] addr;
    logic [SAMPLE_W-1:0]  wdata;
  } ir_mem_req_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {REC_IDLE, REC_DELAY, REC_CAPTURE} rec_state_t;

  typedef enum logic [1:0] {CONV_IDLE, CONV_RUN, CONV_DRAIN} conv_state_t;

endpackage

`default_nettype wire

// File: logic/reverb_top.sv
`default_nettype none

module reverb_top (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  reverb_pkg::apb_req_t     apb_req,
  output reverb_pkg::apb_rsp_t     apb_rsp,
  input  reverb_pkg::audio_sample_t sample,
  output reverb_pkg::conv_result_t result
);
  import reverb_pkg::*;

  logic                record_start;
  logic [DELAY_W-1:0]  delay_len;
  logic                ir_ready;
  logic                recording;
  ir_mem_req_t         rec_req;
  ir_mem_req_t         conv_req;
  logic                rec_grant;
  logic                conv_grant;
  logic [SAMPLE_W-1:0] ir_rdata;

  apb_ctrl_regs u_regs (
    .audio_clk    (audio_clk),
    .reset        (reset),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .ir_ready     (ir_ready),
    .recording    (recording),
    .record_start (record_start),
    .delay_len    (delay_len)
  );

  impulse_recorder u_recorder (
    .audio_clk    (audio_clk),
    .reset        (reset),
    .sample       (sample),
    .record_start (record_start),
    .delay_len    (delay_len),
    .mem_req      (rec_req),
    .mem_grant    (rec_grant),
    .ir_ready     (ir_ready),
    .recording    (recording)
  );

  convolution_engine u_engine (
    .audio_clk (audio_clk),
    .reset     (reset),
    .sample    (sample),
    .ir_ready  (ir_ready),
    .mem_req   (conv_req),
    .mem_grant (conv_grant),
    .mem_rdata (ir_rdata),
    .result    (result)
  );

  ir_memory_arbiter u_ir_mem (
    .audio_clk  (audio_clk),
    .reset      (reset),
    .rec_req    (rec_req),   // requester 0, priority
    .conv_req   (conv_req),
    .rec_grant  (rec_grant),
    .conv_grant (conv_grant),
    .rdata      (ir_rdata)
  );

endmodule

`default_nettype wire
